// ==== hdl/periph_bus_pkg.sv ====
/* OBI and register-bus structs, peripheral address map,
   GPIO and timer register offsets, byte-strobe merge function */

package periph_bus_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  localparam int NUM_PERIPH = 3;
  localparam int PERIPH_SEL_W = 2;
  localparam int PLIC_IDX = 0;
  localparam int GPIO_IDX = 1;
  localparam int TIMER_IDX = 2;

  // Selector in bits 9:8, everything from bit 10 up must be zero
  localparam int ADDR_SEL_LSB = 8;
  localparam int ADDR_UPPER_LSB = 10;

  localparam logic [7:0] GPIO_DIN = 8'h00;
  localparam logic [7:0] GPIO_DOUT = 8'h04;
  localparam logic [7:0] GPIO_OE = 8'h08;
  localparam logic [7:0] GPIO_IE = 8'h0C;
  localparam logic [7:0] GPIO_STATUS = 8'h10;

  localparam logic [7:0] TIMER_MTIME = 8'h00;
  localparam logic [7:0] TIMER_MTIMECMP = 8'h04;
  localparam logic [7:0] TIMER_CTRL = 8'h08;

  function automatic logic [31:0] merge_wstrb(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  wstrb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        merged[8*b+:8] = new_word[8*b+:8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== hdl/periph_irq_pkg.sv ====
/* Interrupt source numbering and counts, PLIC register offsets */

package periph_irq_pkg;

  localparam int NUM_UART_INT = 8;
  localparam int NUM_GPIO = 8;
  localparam int NUM_EXT_INT = 4;
  // ID 0 is reserved and tied low
  localparam int NUM_SRC = 1 + NUM_UART_INT + NUM_GPIO + NUM_EXT_INT;

  localparam int UART_BASE = 1;
  localparam int GPIO_BASE = UART_BASE + NUM_UART_INT;
  localparam int EXT_BASE = GPIO_BASE + NUM_GPIO;

  localparam int PRIO_W = 3;
  localparam int SRC_ID_W = 5;

  // Priority of source n sits at word n
  localparam logic [7:0] PLIC_ENABLE = 8'h80;
  localparam logic [7:0] PLIC_PENDING = 8'h84;
  localparam logic [7:0] PLIC_THRESHOLD = 8'h88;
  localparam logic [7:0] PLIC_CLAIM = 8'h8C;
  localparam logic [7:0] PLIC_MSIP = 8'h90;

endpackage

// ==== hdl/obi_to_reg.sv ====
/* OBI slave to internal register bus bridge, one response stage */

`timescale 1ns/1ps

module obi_to_reg
  import periph_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // Every request is accepted in its own cycle
  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.wstrb = obi_req_i.be;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
      err_q    <= obi_req_i.req & reg_rsp_i.error;
    end
  end

  // Read data captured in the grant cycle
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= reg_rsp_i.rdata;
    end
  end

  assign obi_resp_o.gnt    = obi_req_i.req;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

endmodule

// ==== hdl/reg_demux.sv ====
/* Register bus address decoder and demux to the peripheral ports */

`timescale 1ns/1ps

module reg_demux
  import periph_bus_pkg::*;
(
  input  reg_req_t                  req_i,
  output reg_rsp_t                  rsp_o,
  output reg_req_t [NUM_PERIPH-1:0] periph_req_o,
  input  reg_rsp_t [NUM_PERIPH-1:0] periph_rsp_i
);

  logic [PERIPH_SEL_W-1:0] sel;
  logic                    upper_zero;
  logic                    mapped;

  assign sel        = req_i.addr[ADDR_SEL_LSB+:PERIPH_SEL_W];
  assign upper_zero = (req_i.addr[31:ADDR_UPPER_LSB] == '0);
  assign mapped     = upper_zero && (sel < PERIPH_SEL_W'(NUM_PERIPH));

  // Same payload everywhere, valid only on the selected port
  always_comb begin
    for (int i = 0; i < NUM_PERIPH; i++) begin
      periph_req_o[i]       = req_i;
      periph_req_o[i].valid = req_i.valid && mapped && (sel == PERIPH_SEL_W'(i));
    end
  end

  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.error = 1'b1;
    for (int i = 0; i < NUM_PERIPH; i++) begin
      if (mapped && (sel == PERIPH_SEL_W'(i))) begin
        rsp_o = periph_rsp_i[i];
      end
    end
  end

endmodule

// ==== hdl/plic_lite.sv ====
/* Small PLIC: level gateways, per-source priority, enable mask,
   threshold, claim/complete and software interrupt bit */

`timescale 1ns/1ps

module plic_lite
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  reg_req_t           reg_req_i,
  output reg_rsp_t           reg_rsp_o,
  input  logic [NUM_SRC-1:0] intr_src_i,
  output logic               irq_o,
  output logic               msip_o
);

  logic [NUM_SRC-1:0][PRIO_W-1:0] prio_q;
  logic [NUM_SRC-1:0]             enable_q;
  logic [NUM_SRC-1:0]             pending_q;
  logic [NUM_SRC-1:0]             in_service_q;
  logic [PRIO_W-1:0]              threshold_q;
  logic                           msip_q;

  logic [5:0]          word;
  logic [31:0]         rdata;
  logic [31:0]         wr_data;
  logic                wr_en;
  logic                claim_rd;
  logic                complete_wr;
  logic [SRC_ID_W-1:0] best_id;
  logic [PRIO_W-1:0]   best_prio;

  assign word = reg_req_i.addr[7:2];

  // Strict compare keeps the lowest ID on a tie
  always_comb begin
    best_id   = '0;
    best_prio = threshold_q;
    for (int i = 1; i < NUM_SRC; i++) begin
      if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
        best_id   = SRC_ID_W'(i);
        best_prio = prio_q[i];
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (word < 6'(NUM_SRC)) begin
      rdata[PRIO_W-1:0] = prio_q[word];
    end else if (word == PLIC_ENABLE[7:2]) begin
      rdata[NUM_SRC-1:0] = enable_q;
    end else if (word == PLIC_PENDING[7:2]) begin
      rdata[NUM_SRC-1:0] = pending_q;
    end else if (word == PLIC_THRESHOLD[7:2]) begin
      rdata[PRIO_W-1:0] = threshold_q;
    end else if (word == PLIC_CLAIM[7:2]) begin
      rdata[SRC_ID_W-1:0] = best_id;
    end else if (word == PLIC_MSIP[7:2]) begin
      rdata[0] = msip_q;
    end
  end

  assign wr_data     = merge_wstrb(rdata, reg_req_i.wdata, reg_req_i.wstrb);
  assign wr_en       = reg_req_i.valid & reg_req_i.write;
  assign claim_rd    = reg_req_i.valid & ~reg_req_i.write & (word == PLIC_CLAIM[7:2]) &
                       (best_id != '0);
  assign complete_wr = wr_en & (word == PLIC_CLAIM[7:2]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q       <= '0;
      enable_q     <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
      threshold_q  <= '0;
      msip_q       <= 1'b0;
    end else begin
      // Source 0 is never written, its entries stay zero
      for (int i = 1; i < NUM_SRC; i++) begin
        if (wr_en && (word == 6'(i))) begin
          prio_q[i] <= wr_data[PRIO_W-1:0];
        end
        if (claim_rd && (best_id == SRC_ID_W'(i))) begin
          pending_q[i]    <= 1'b0;
          in_service_q[i] <= 1'b1;
        end else begin
          if (intr_src_i[i] && !in_service_q[i]) begin
            pending_q[i] <= 1'b1;
          end
          if (complete_wr && (wr_data[SRC_ID_W-1:0] == SRC_ID_W'(i))) begin
            in_service_q[i] <= 1'b0;
          end
        end
      end
      if (wr_en && (word == PLIC_ENABLE[7:2])) begin
        enable_q <= wr_data[NUM_SRC-1:0];
      end
      if (wr_en && (word == PLIC_THRESHOLD[7:2])) begin
        threshold_q <= wr_data[PRIO_W-1:0];
      end
      if (wr_en && (word == PLIC_MSIP[7:2])) begin
        msip_q <= wr_data[0];
      end
    end
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = 1'b0;
  assign irq_o           = (best_id != '0);
  assign msip_o          = msip_q;

endmodule

// ==== hdl/gpio_port.sv ====
/* GPIO block: data out, output enable, input synchronizer,
   rising-edge status with write-1-to-clear and per-pin interrupts */

`timescale 1ns/1ps

module gpio_port
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  reg_req_t            reg_req_i,
  output reg_rsp_t            reg_rsp_o,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_en_o,
  output logic [NUM_GPIO-1:0] intr_o
);

  logic [NUM_GPIO-1:0] sync_q1, sync_q2, sync_prev_q;
  logic [NUM_GPIO-1:0] out_q, oe_q, ie_q, status_q;
  logic [NUM_GPIO-1:0] rise;
  logic [5:0]          word;
  logic [31:0]         rdata;
  logic [31:0]         wr_data;
  logic [31:0]         clr_mask;
  logic                wr_en;

  assign word  = reg_req_i.addr[7:2];
  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign rise  = sync_q2 & ~sync_prev_q;

  always_comb begin
    rdata = '0;
    case (word)
      GPIO_DIN[7:2]:    rdata[NUM_GPIO-1:0] = sync_q2;
      GPIO_DOUT[7:2]:   rdata[NUM_GPIO-1:0] = out_q;
      GPIO_OE[7:2]:     rdata[NUM_GPIO-1:0] = oe_q;
      GPIO_IE[7:2]:     rdata[NUM_GPIO-1:0] = ie_q;
      GPIO_STATUS[7:2]: rdata[NUM_GPIO-1:0] = status_q;
      default:          rdata = '0;
    endcase
  end

  assign wr_data  = merge_wstrb(rdata, reg_req_i.wdata, reg_req_i.wstrb);
  // Only strobed bytes can clear status
  assign clr_mask = merge_wstrb('0, reg_req_i.wdata, reg_req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1     <= '0;
      sync_q2     <= '0;
      sync_prev_q <= '0;
      out_q       <= '0;
      oe_q        <= '0;
      ie_q        <= '0;
      status_q    <= '0;
    end else begin
      sync_q1     <= gpio_i;
      sync_q2     <= sync_q1;
      sync_prev_q <= sync_q2;
      if (wr_en && (word == GPIO_DOUT[7:2])) out_q <= wr_data[NUM_GPIO-1:0];
      if (wr_en && (word == GPIO_OE[7:2])) oe_q <= wr_data[NUM_GPIO-1:0];
      if (wr_en && (word == GPIO_IE[7:2])) ie_q <= wr_data[NUM_GPIO-1:0];
      if (wr_en && (word == GPIO_STATUS[7:2])) begin
        status_q <= (status_q & ~clr_mask[NUM_GPIO-1:0]) | rise;
      end else begin
        status_q <= status_q | rise;
      end
    end
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = 1'b0;
  assign gpio_o          = out_q;
  assign gpio_en_o       = oe_q;
  assign intr_o          = status_q & ie_q;

endmodule

// ==== hdl/mtimer.sv ====
/* Machine timer: free-running mtime, mtimecmp and registered compare interrupt */

`timescale 1ns/1ps

module mtimer
  import periph_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     intr_o
);

  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic        enable_q;
  logic        intr_q;
  logic [5:0]  word;
  logic [31:0] rdata;
  logic [31:0] wr_data;
  logic        wr_en;

  assign word  = reg_req_i.addr[7:2];
  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_comb begin
    rdata = '0;
    case (word)
      TIMER_MTIME[7:2]:    rdata = mtime_q;
      TIMER_MTIMECMP[7:2]: rdata = mtimecmp_q;
      TIMER_CTRL[7:2]:     rdata[0] = enable_q;
      default:             rdata = '0;
    endcase
  end

  assign wr_data = merge_wstrb(rdata, reg_req_i.wdata, reg_req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      enable_q   <= 1'b0;
      intr_q     <= 1'b0;
    end else begin
      // A software write wins over the increment
      if (wr_en && (word == TIMER_MTIME[7:2])) begin
        mtime_q <= wr_data;
      end else if (enable_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr_en && (word == TIMER_MTIMECMP[7:2])) mtimecmp_q <= wr_data;
      if (wr_en && (word == TIMER_CTRL[7:2])) enable_q <= wr_data[0];
      intr_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = 1'b0;
  assign intr_o          = intr_q;

endmodule

// ==== hdl/peripheral_subsystem.sv ====
/* Peripheral subsystem top: OBI bridge, register demux, PLIC, GPIO and timer */

`timescale 1ns/1ps

module peripheral_subsystem
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  obi_req_t                slave_req_i,
  output obi_resp_t               slave_resp_o,
  input  logic [NUM_UART_INT-1:0] uart_intr_i,
  input  logic [NUM_EXT_INT-1:0]  ext_intr_i,
  output logic                    irq_plic_o,
  output logic                    msip_o,
  input  logic [NUM_GPIO-1:0]     cio_gpio_i,
  output logic [NUM_GPIO-1:0]     cio_gpio_o,
  output logic [NUM_GPIO-1:0]     cio_gpio_en_o,
  output logic                    timer_intr_o
);

  reg_req_t                  bridge_req;
  reg_rsp_t                  bridge_rsp;
  reg_req_t [NUM_PERIPH-1:0] periph_req;
  reg_rsp_t [NUM_PERIPH-1:0] periph_rsp;
  logic [NUM_SRC-1:0]        intr_src;
  logic [NUM_GPIO-1:0]       gpio_intr;

  // ID 0 means no interrupt and stays low
  assign intr_src[0]                          = 1'b0;
  assign intr_src[UART_BASE+:NUM_UART_INT]    = uart_intr_i;
  assign intr_src[GPIO_BASE+:NUM_GPIO]        = gpio_intr;
  assign intr_src[EXT_BASE+:NUM_EXT_INT]      = ext_intr_i;

  obi_to_reg u_obi_to_reg (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (bridge_req),
    .reg_rsp_i (bridge_rsp)
  );

  reg_demux u_reg_demux (
    .req_i       (bridge_req),
    .rsp_o       (bridge_rsp),
    .periph_req_o(periph_req),
    .periph_rsp_i(periph_rsp)
  );

  plic_lite u_plic (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .reg_req_i (periph_req[PLIC_IDX]),
    .reg_rsp_o (periph_rsp[PLIC_IDX]),
    .intr_src_i(intr_src),
    .irq_o     (irq_plic_o),
    .msip_o    (msip_o)
  );

  gpio_port u_gpio (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .reg_req_i(periph_req[GPIO_IDX]),
    .reg_rsp_o(periph_rsp[GPIO_IDX]),
    .gpio_i   (cio_gpio_i),
    .gpio_o   (cio_gpio_o),
    .gpio_en_o(cio_gpio_en_o),
    .intr_o   (gpio_intr)
  );

  mtimer u_mtimer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .reg_req_i(periph_req[TIMER_IDX]),
    .reg_rsp_o(periph_rsp[TIMER_IDX]),
    .intr_o   (timer_intr_o)
  );

endmodule

// ==== tb/peripheral_subsystem_assert.sv ====
/* Concurrent assertions on OBI grant and response timing, reset values
   and PLIC masking, bound into the peripheral subsystem */

`timescale 1ns/1ps

module peripheral_subsystem_assert
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
(
  input logic                clk_i,
  input logic                reset_i,
  input obi_req_t            slave_req_i,
  input obi_resp_t           slave_resp_i,
  input logic                irq_plic_i,
  input logic                msip_i,
  input logic                timer_intr_i,
  input logic [NUM_GPIO-1:0] gpio_out_i,
  input logic [NUM_GPIO-1:0] gpio_en_i,
  input logic [NUM_SRC-1:0]  plic_enable_i
);

  int unsigned fail_count = 0;

  gnt_equals_req: assert property (@(posedge clk_i) disable iff (reset_i)
    slave_resp_i.gnt == slave_req_i.req)
    else begin
      fail_count++;
      $error("OBI gnt differs from req");
    end

  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    slave_resp_i.gnt |=> slave_resp_i.rvalid)
    else begin
      fail_count++;
      $error("OBI rvalid missing one cycle after a grant");
    end

  // No response without a grant the cycle before
  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    !slave_resp_i.gnt |=> !slave_resp_i.rvalid)
    else begin
      fail_count++;
      $error("OBI rvalid without a preceding grant");
    end

  outputs_low_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !irq_plic_i && !msip_i && !timer_intr_i && gpio_out_i == '0 &&
                gpio_en_i == '0 && !slave_resp_i.rvalid && !slave_resp_i.err)
    else begin
      fail_count++;
      $error("Control output high in the cycle after reset");
    end

  irq_masked: assert property (@(posedge clk_i) disable iff (reset_i)
    plic_enable_i == '0 |-> !irq_plic_i)
    else begin
      fail_count++;
      $error("PLIC interrupt raised with an all-zero enable mask");
    end

endmodule

bind peripheral_subsystem peripheral_subsystem_assert u_assert (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .slave_req_i  (slave_req_i),
  .slave_resp_i (slave_resp_o),
  .irq_plic_i   (irq_plic_o),
  .msip_i       (msip_o),
  .timer_intr_i (timer_intr_o),
  .gpio_out_i   (cio_gpio_o),
  .gpio_en_i    (cio_gpio_en_o),
  .plic_enable_i(u_plic.enable_q)
);

// ==== tb/peripheral_subsystem_tb.sv ====
/* Testbench for the peripheral subsystem: clock, reset, OBI access tasks,
   register, decode, interrupt and timer stimulus with checks and closing report */

`timescale 1ns/1ps

module peripheral_subsystem_tb
  import periph_bus_pkg::*;
  import periph_irq_pkg::*;
();

  localparam logic [31:0] PLIC_ADDR  = 32'h0000_0000;
  localparam logic [31:0] GPIO_ADDR  = 32'h0000_0100;
  localparam logic [31:0] TIMER_ADDR = 32'h0000_0200;
  // About 60 bus accesses plus interrupt waits stay under 600 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RESP_LIMIT = 4;

  logic       clk;
  logic       reset;
  obi_req_t   slave_req;
  obi_resp_t  slave_resp;
  logic [7:0] uart_intr;
  logic [3:0] ext_intr;
  logic       irq_plic;
  logic       msip;
  logic [7:0] gpio_in;
  logic [7:0] gpio_out;
  logic [7:0] gpio_en;
  logic       timer_intr;
  int         errors;
  int         cycle_count;
  int         seed;

  peripheral_subsystem u_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .slave_req_i  (slave_req),
    .slave_resp_o (slave_resp),
    .uart_intr_i  (uart_intr),
    .ext_intr_i   (ext_intr),
    .irq_plic_o   (irq_plic),
    .msip_o       (msip),
    .cio_gpio_i   (gpio_in),
    .cio_gpio_o   (gpio_out),
    .cio_gpio_en_o(gpio_en),
    .timer_intr_o (timer_intr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, test sequence did not finish", cycle_count);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // Expected register value after a write with byte strobes
  function automatic logic [31:0] strobe_update(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic obi_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            output logic [31:0] rdata, output logic err);
    int wait_cycles;
    @(posedge clk);
    slave_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(negedge clk);
    wait_cycles = 0;
    while (!slave_resp.gnt && wait_cycles < RESP_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    // Grant cycle ends here
    @(posedge clk);
    slave_req.req <= 1'b0;
    @(negedge clk);
    wait_cycles = 0;
    while (!slave_resp.rvalid && wait_cycles < RESP_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    assert (slave_resp.rvalid) else begin
      errors++;
      $display("No OBI response for the access at address 0x%08h", addr);
    end
    rdata = slave_resp.rdata;
    err   = slave_resp.err;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    obi_access(1'b1, addr, data, be, rdata, err);
    check_value("slave_resp_o.err", err, 32'h0);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    obi_access(1'b0, addr, 32'h0, 4'h0, rdata, err);
    check_value("slave_resp_o.err", err, 32'h0);
    check_value(name, rdata, exp);
  endtask

  function automatic logic output_level(input string name);
    case (name)
      "irq_plic_o":   return irq_plic;
      "timer_intr_o": return timer_intr;
      default:        return msip;
    endcase
  endfunction

  task automatic wait_output(input string name, input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (output_level(name) !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    assert (output_level(name) === level) else begin
      errors++;
      $display("%s did not reach %0d within %0d cycles", name, level, limit);
    end
  endtask

  initial begin
    logic [31:0] gpio_dout_m;
    logic [31:0] gpio_oe_m;
    logic [31:0] mtimecmp_m;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] target;
    logic [3:0]  be;
    logic        err;
    clk         = 1'b0;
    reset       = 1'b1;
    slave_req   = '0;
    uart_intr   = '0;
    ext_intr    = '0;
    gpio_in     = '0;
    errors      = 0;
    cycle_count = 0;
    seed        = 22;
    gpio_dout_m = '0;
    gpio_oe_m   = '0;
    mtimecmp_m  = '1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // Random writes with partial strobes against the byte model
    for (int i = 0; i < 9; i++) begin
      wdata = $random(seed);
      be    = $random(seed);
      case (i % 3)
        0: begin
          gpio_dout_m = strobe_update(gpio_dout_m, wdata, be) & 32'hFF;
          bus_write(GPIO_ADDR + GPIO_DOUT, wdata, be);
          read_check("GPIO_DOUT", GPIO_ADDR + GPIO_DOUT, gpio_dout_m);
        end
        1: begin
          gpio_oe_m = strobe_update(gpio_oe_m, wdata, be) & 32'hFF;
          bus_write(GPIO_ADDR + GPIO_OE, wdata, be);
          read_check("GPIO_OE", GPIO_ADDR + GPIO_OE, gpio_oe_m);
        end
        default: begin
          mtimecmp_m = strobe_update(mtimecmp_m, wdata, be);
          bus_write(TIMER_ADDR + TIMER_MTIMECMP, wdata, be);
          read_check("MTIMECMP", TIMER_ADDR + TIMER_MTIMECMP, mtimecmp_m);
        end
      endcase
      check_value("cio_gpio_o", gpio_out, gpio_dout_m);
      check_value("cio_gpio_en_o", gpio_en, gpio_oe_m);
    end

    // Selector 3 and nonzero upper bits with writes on even steps
    for (int i = 0; i < 4; i++) begin
      case (i)
        0:       target = 32'h0000_0304;
        1:       target = 32'h0000_0300;
        2:       target = 32'h0000_0504;
        default: target = 32'h8000_0108;
      endcase
      obi_access((i % 2) == 0, target, 32'hFFFF_FFFF, 4'hF, rdata, err);
      check_value("slave_resp_o.err", err, 32'h1);
      check_value("slave_resp_o.rdata", rdata, 32'h0);
    end
    read_check("GPIO_DOUT", GPIO_ADDR + GPIO_DOUT, gpio_dout_m);
    read_check("GPIO_OE", GPIO_ADDR + GPIO_OE, gpio_oe_m);
    read_check("MTIMECMP", TIMER_ADDR + TIMER_MTIMECMP, mtimecmp_m);

    // Pin 3 is PLIC source 12
    bus_write(PLIC_ADDR + 4 * 12, 32'd5, 4'hF);
    bus_write(PLIC_ADDR + PLIC_THRESHOLD, 32'd1, 4'hF);
    bus_write(PLIC_ADDR + PLIC_ENABLE, 32'h1 << 12, 4'hF);
    bus_write(GPIO_ADDR + GPIO_IE, 32'h08, 4'hF);
    @(posedge clk);
    gpio_in[3] <= 1'b1;
    wait_output("irq_plic_o", 1'b1, 8);
    read_check("GPIO_STATUS", GPIO_ADDR + GPIO_STATUS, 32'h08);
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd12);
    check_value("irq_plic_o", irq_plic, 32'h0);
    read_check("GPIO_STATUS", GPIO_ADDR + GPIO_STATUS, 32'h08);
    bus_write(GPIO_ADDR + GPIO_STATUS, 32'h08, 4'h1);
    read_check("GPIO_STATUS", GPIO_ADDR + GPIO_STATUS, 32'h0);
    bus_write(PLIC_ADDR + PLIC_CLAIM, 32'd12, 4'hF);
    @(posedge clk);
    gpio_in[3] <= 1'b0;
    // Falling edge passes the synchronizer and must not set status
    repeat (6) @(negedge clk);
    check_value("irq_plic_o", irq_plic, 32'h0);
    read_check("GPIO_STATUS", GPIO_ADDR + GPIO_STATUS, 32'h0);

    // UART sources 1..5 with priorities 2, 6, 6, 4, 1 against threshold 1
    bus_write(PLIC_ADDR + 4 * 1, 32'd2, 4'hF);
    bus_write(PLIC_ADDR + 4 * 2, 32'd6, 4'hF);
    bus_write(PLIC_ADDR + 4 * 3, 32'd6, 4'hF);
    bus_write(PLIC_ADDR + 4 * 4, 32'd4, 4'hF);
    bus_write(PLIC_ADDR + 4 * 5, 32'd1, 4'hF);
    bus_write(PLIC_ADDR + PLIC_ENABLE, 32'h3E, 4'hF);
    @(posedge clk);
    uart_intr <= 8'h1F;
    wait_output("irq_plic_o", 1'b1, 4);
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd2);
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd3);
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd4);
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd1);
    // Source 5 stays pending at the threshold
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd0);
    check_value("irq_plic_o", irq_plic, 32'h0);
    read_check("PLIC_PENDING", PLIC_ADDR + PLIC_PENDING, 32'h20);
    bus_write(PLIC_ADDR + PLIC_CLAIM, 32'd2, 4'hF);
    wait_output("irq_plic_o", 1'b1, 4);
    bus_write(PLIC_ADDR + PLIC_ENABLE, 32'h0, 4'hF);
    check_value("irq_plic_o", irq_plic, 32'h0);
    bus_write(PLIC_ADDR + PLIC_ENABLE, 32'h3E, 4'hF);
    read_check("PLIC_CLAIM", PLIC_ADDR + PLIC_CLAIM, 32'd2);
    @(posedge clk);
    uart_intr <= '0;
    for (int id = 1; id <= 4; id++) begin
      bus_write(PLIC_ADDR + PLIC_CLAIM, id, 4'hF);
    end
    repeat (2) @(negedge clk);
    check_value("irq_plic_o", irq_plic, 32'h0);

    // Timer compare at 10 and then far ahead
    bus_write(TIMER_ADDR + TIMER_MTIME, 32'd0, 4'hF);
    bus_write(TIMER_ADDR + TIMER_MTIMECMP, 32'd10, 4'hF);
    bus_write(TIMER_ADDR + TIMER_CTRL, 32'd1, 4'hF);
    check_value("timer_intr_o", timer_intr, 32'h0);
    wait_output("timer_intr_o", 1'b1, 10 + 3);
    bus_write(TIMER_ADDR + TIMER_MTIMECMP, 32'hFFFF_0000, 4'hF);
    wait_output("timer_intr_o", 1'b0, 3);

    bus_write(PLIC_ADDR + PLIC_MSIP, 32'd1, 4'hF);
    check_value("msip_o", msip, 32'h1);
    bus_write(PLIC_ADDR + PLIC_MSIP, 32'd0, 4'hF);
    check_value("msip_o", msip, 32'h0);

    $display("Check errors: %0d, assertion failures: %0d", errors,
             u_dut.u_assert.fail_count);
    if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== peripheral_subsystem.f ====
hdl/periph_bus_pkg.sv
hdl/periph_irq_pkg.sv
hdl/obi_to_reg.sv
hdl/reg_demux.sv
hdl/plic_lite.sv
hdl/gpio_port.sv
hdl/mtimer.sv
hdl/peripheral_subsystem.sv
tb/peripheral_subsystem_assert.sv
tb/peripheral_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: peripheral_subsystem

sources:
  - files:
      - hdl/periph_bus_pkg.sv
      - hdl/periph_irq_pkg.sv
      - hdl/obi_to_reg.sv
      - hdl/reg_demux.sv
      - hdl/plic_lite.sv
      - hdl/gpio_port.sv
      - hdl/mtimer.sv
      - hdl/peripheral_subsystem.sv
  - target: test
    files:
      - tb/peripheral_subsystem_assert.sv
      - tb/peripheral_subsystem_tb.sv
